// ==== common/i2c_config.svh ====
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// build-time constants for the I2C slave peripheral

// the 7-bit address that the slave acknowledges
// any other address byte leaves the slave silent until the next start
`define I2C_SLAVE_ADDR 7'h27

// number of equal consecutive CLK samples a bus line must show
// before its filtered level follows
// pulses shorter than this never reach the slave logic
`define DEGLITCH_SAMPLES 4

// the filter adds this many CLK cycles of delay to every SCL and SDA edge
// so the SCL quarter period must be well above it
// at 4 samples the deglitch delay is four CLK periods

// the slave never stretches SCL
// timing margin comes from the master's clock rate alone

`endif

// ==== common/i2c_pkg.sv ====
package i2c_pkg;

	// a 7-bit I2C slave address as it sits in bits 7:1 of the address byte
	typedef logic [6:0] addr_t;

	// one byte as it moves on SDA, MSB first
	typedef logic [7:0] byte_t;

	// the 16-bit control word loaded by writes
	// the same width carries the status word returned by reads
	typedef logic [15:0] word_t;

	// bits seen so far in the current byte
	// it runs from 0 to 8 and holds at 8 through the acknowledge pulse
	typedef logic [3:0] bit_cnt_t;

	// slave sequencing states
	// ADDR shifts in the address byte and ADDR_ACK answers it
	// WRITE and WRITE_ACK take data bytes from the master
	// READ and READ_ACK send status bytes to the master
	// IGNORE waits out a transfer meant for another slave or ended by a NACK
	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		ADDR_ACK,
		WRITE,
		WRITE_ACK,
		READ,
		READ_ACK,
		IGNORE
	} i2c_state_e;

endpackage

// ==== dv/tb_i2c_periph.sv ====
`timescale 1ns/1ps
`include "i2c_config.svh"

module tb_i2c_periph;
	import i2c_pkg::*;

	// one SCL quarter period in CLK cycles, so one bit takes 160 cycles
	localparam int Q = 40;
	// bus pulses this short must never get through the filters
	localparam int GLITCH_LEN = `DEGLITCH_SAMPLES - 2;
	// about 30000 cycles of traffic in all, the limit leaves a wide margin
	localparam int MAX_CYCLES = 100000;
	localparam addr_t SLAVE_ADDR = `I2C_SLAVE_ADDR;

	logic  CLK;
	logic  reset;
	word_t status;
	word_t ctrl_word;
	wire   scl;
	wire   sda;
	// the master pulls a line low when its pull flag is set
	logic  scl_pull;
	logic  sda_pull;

	logic [31:0] rng;
	word_t       exp_ctrl;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          pending = 0;
	// checks waiting for the compare process
	string       chk_name[$];
	word_t       chk_got[$];
	word_t       chk_want[$];

	assign scl = scl_pull ? 1'b0 : 1'bz;
	assign sda = sda_pull ? 1'b0 : 1'bz;
	pullup (scl);
	pullup (sda);

	i2c_periph_top dut_i (
		.CLK(CLK), .reset(reset), .scl(scl), .sda(sda),
		.status(status), .ctrl_word(ctrl_word)
	);

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected control word after n written bytes, byte i sits at data[8*i +: 8]
	// the first byte of a transfer lands low and later bytes alternate halves
	function automatic word_t model_ctrl(input word_t prev, input logic [31:0] data, input int n);
		word_t w;
		int    i;
		w = prev;
		for (i = 0; i < n; i++) begin
			if (i % 2 == 0) begin
				w[7:0] = data[8*i +: 8];
			end else begin
				w[15:8] = data[8*i +: 8];
			end
		end
		return w;
	endfunction

	task automatic rand_byte(output byte_t b);
		rng = lcg_next(rng);
		b = rng[23:16];
	endtask

	// every wait ends 1 ns after a rising edge, where inputs change
	task automatic wait_clks(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	task automatic queue_check(input string name, input word_t got, input word_t want);
		chk_name.push_back(name);
		chk_got.push_back(got);
		chk_want.push_back(want);
		pending = pending + 1;
	endtask

	// one SCL pulse with SDA set a quarter period after the last fall
	// seen is SDA in the middle of the high phase
	// with glitch set, SCL jumps high briefly while low and SDA flips briefly while SCL is high
	task automatic clock_bit(input logic bit_val, input logic glitch, output logic seen);
		sda_pull = ~bit_val;
		if (glitch) begin
			wait_clks(Q / 2);
			scl_pull = 1'b0;
			wait_clks(GLITCH_LEN);
			scl_pull = 1'b1;
			wait_clks(Q - Q / 2 - GLITCH_LEN);
		end else begin
			wait_clks(Q);
		end
		scl_pull = 1'b0;
		if (glitch) begin
			wait_clks(Q / 2);
			sda_pull = bit_val;
			wait_clks(GLITCH_LEN);
			sda_pull = ~bit_val;
			wait_clks(Q - Q / 2 - GLITCH_LEN);
		end else begin
			wait_clks(Q);
		end
		seen = sda;
		wait_clks(Q);
		scl_pull = 1'b1;
		wait_clks(Q);
	endtask

	// works from an idle bus and as a repeated start with SCL low
	task automatic send_start();
		sda_pull = 1'b0;
		wait_clks(Q);
		scl_pull = 1'b0;
		wait_clks(Q);
		sda_pull = 1'b1;
		wait_clks(Q);
		scl_pull = 1'b1;
		wait_clks(Q);
	endtask

	task automatic send_stop();
		sda_pull = 1'b1;
		wait_clks(Q);
		scl_pull = 1'b0;
		wait_clks(Q);
		sda_pull = 1'b0;
		wait_clks(Q);
	endtask

	// eight data bits MSB first, then SDA released for the slave's answer
	task automatic write_byte(input byte_t b, input logic glitch, output logic nack);
		logic seen;
		int   i;
		for (i = 7; i >= 0; i--) begin
			clock_bit(b[i], glitch, seen);
		end
		clock_bit(1'b1, 1'b0, nack);
	endtask

	task automatic send_ack(input logic ack);
		logic seen;
		clock_bit(~ack, 1'b0, seen);
	endtask

	task automatic read_byte(input logic ack, output byte_t b);
		logic seen;
		int   i;
		for (i = 7; i >= 0; i--) begin
			clock_bit(1'b1, 1'b0, seen);
			b[i] = seen;
		end
		send_ack(ack);
	endtask

	// a whole write transfer, data bytes only go out after an address ack
	task automatic write_xfer(input addr_t addr, input logic [31:0] data, input int n,
			input logic glitch);
		logic nack;
		int   i;
		send_start();
		write_byte({addr, 1'b0}, glitch, nack);
		queue_check("sda at address ack", {15'd0, nack}, {15'd0, addr != SLAVE_ADDR});
		if (!nack) begin
			for (i = 0; i < n; i++) begin
				write_byte(data[8*i +: 8], glitch, nack);
				queue_check("sda at data ack", {15'd0, nack}, 16'h0000);
			end
		end
		send_stop();
	endtask

	// compares queued results in order as they arrive
	initial begin : compare_proc
		string name;
		word_t got;
		word_t want;
		forever begin
			wait (pending > 0);
			name = chk_name.pop_front();
			got = chk_got.pop_front();
			want = chk_want.pop_front();
			checks = checks + 1;
			assert (got === want) else begin
				errors = errors + 1;
				$display("error: %s is 0x%h, expected 0x%h", name, got, want);
			end
			pending = pending - 1;
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin : stimulus
		logic [31:0] data;
		byte_t       b0;
		byte_t       b1;
		byte_t       b2;
		byte_t       rd_lo;
		byte_t       rd_hi;
		word_t       snap_val;
		logic        nack;
		rng = 32'h5a7e;
		reset = 1'b1;
		status = '0;
		scl_pull = 1'b0;
		sda_pull = 1'b0;
		exp_ctrl = '0;
		// reset held over three rising edges, with the bus released throughout
		wait_clks(1);
		queue_check("sda in reset", {15'd0, sda}, 16'h0001);
		queue_check("ctrl_word in reset", ctrl_word, 16'h0000);
		wait_clks(2);
		reset = 1'b0;
		wait_clks(1);
		queue_check("sda after reset", {15'd0, sda}, 16'h0001);
		queue_check("ctrl_word after reset", ctrl_word, 16'h0000);
		wait_clks(10);

		// two-byte write to the slave
		rand_byte(b0);
		rand_byte(b1);
		data = {16'd0, b1, b0};
		write_xfer(SLAVE_ADDR, data, 2, 1'b0);
		exp_ctrl = model_ctrl(exp_ctrl, data, 2);
		queue_check("ctrl_word", ctrl_word, exp_ctrl);

		// another address must be ignored
		rand_byte(b0);
		write_xfer(SLAVE_ADDR ^ 7'h01, {24'd0, b0}, 1, 1'b0);
		queue_check("ctrl_word", ctrl_word, exp_ctrl);

		// read, with status moving once the address is acknowledged
		rand_byte(b0);
		rand_byte(b1);
		status = {b1, b0};
		snap_val = status;
		send_start();
		write_byte({SLAVE_ADDR, 1'b1}, 1'b0, nack);
		queue_check("sda at read address ack", {15'd0, nack}, 16'h0000);
		status = ~status;
		read_byte(1'b1, rd_lo);
		read_byte(1'b0, rd_hi);
		queue_check("read low byte", {8'd0, rd_lo}, {8'd0, snap_val[7:0]});
		queue_check("read high byte", {8'd0, rd_hi}, {8'd0, snap_val[15:8]});
		queue_check("sda after master nack", {15'd0, sda}, 16'h0001);
		wait_clks(Q);
		queue_check("sda after master nack", {15'd0, sda}, 16'h0001);
		send_stop();
		queue_check("ctrl_word after read", ctrl_word, exp_ctrl);

		// a third byte wraps to the low half
		rand_byte(b0);
		rand_byte(b1);
		rand_byte(b2);
		data = {8'd0, b2, b1, b0};
		write_xfer(SLAVE_ADDR, data, 3, 1'b0);
		exp_ctrl = model_ctrl(exp_ctrl, data, 3);
		queue_check("ctrl_word after wrap", ctrl_word, exp_ctrl);

		// a repeated start sends the next byte to the low half again
		rand_byte(b0);
		rand_byte(b1);
		send_start();
		write_byte({SLAVE_ADDR, 1'b0}, 1'b0, nack);
		queue_check("sda at address ack", {15'd0, nack}, 16'h0000);
		write_byte(b0, 1'b0, nack);
		queue_check("sda at data ack", {15'd0, nack}, 16'h0000);
		exp_ctrl = model_ctrl(exp_ctrl, {24'd0, b0}, 1);
		send_start();
		write_byte({SLAVE_ADDR, 1'b0}, 1'b0, nack);
		queue_check("sda at repeated start ack", {15'd0, nack}, 16'h0000);
		write_byte(b1, 1'b0, nack);
		queue_check("sda at data ack", {15'd0, nack}, 16'h0000);
		exp_ctrl = model_ctrl(exp_ctrl, {24'd0, b1}, 1);
		send_stop();
		queue_check("ctrl_word after repeated start", ctrl_word, exp_ctrl);

		// short pulses on both lines throughout the transfer
		rand_byte(b0);
		rand_byte(b1);
		data = {16'd0, b1, b0};
		write_xfer(SLAVE_ADDR, data, 2, 1'b1);
		exp_ctrl = model_ctrl(exp_ctrl, data, 2);
		queue_check("ctrl_word with glitches", ctrl_word, exp_ctrl);

		wait (pending == 0);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== i2c_slave/i2c_bit_counter.sv ====
`timescale 1ns/1ps

module i2c_bit_counter (
	input  logic              CLK,
	input  logic              reset,
	input  logic              cnt_clear,
	input  logic              scl_rise,
	output logic              byte_done,
	output i2c_pkg::bit_cnt_t bit_count
);
	import i2c_pkg::*;

	localparam bit_cnt_t LAST_BIT = 4'd7;
	localparam bit_cnt_t BYTE_BITS = 4'd8;

	// one count per SCL rise in a data phase
	// the FSM masks the ack rise, so the count rests at 8 until it is cleared
	always_ff @(posedge CLK) begin
		if (reset) begin
			bit_count <= '0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (cnt_clear) begin
				bit_count <= '0;
			end else if (scl_rise) begin
				bit_count <= bit_count + 1'b1;
				// pulses in the cycle after the eighth rise
				byte_done <= (bit_count == LAST_BIT);
			end
		end
	end

	// a ninth counted rise would mean the FSM let an ack pulse through
	assert property (@(posedge CLK) disable iff (reset)
		bit_count <= BYTE_BITS)
		else $error("bit count %0d past the end of a byte", bit_count);

endmodule

// ==== i2c_slave/i2c_reg_bank.sv ====
`timescale 1ns/1ps

module i2c_reg_bank (
	input  logic           CLK,
	input  logic           reset,
	input  logic           start_xfer,
	input  logic           snap_status,
	input  logic           commit_byte,
	input  logic           next_byte,
	input  i2c_pkg::byte_t rx_byte,
	input  i2c_pkg::word_t status,
	output i2c_pkg::byte_t tx_byte,
	output i2c_pkg::word_t ctrl_word
);
	import i2c_pkg::*;

	// 0 selects bits 7:0 and 1 selects bits 15:8
	logic  byte_idx;
	// status as it stood at the address acknowledge of a read
	word_t snap;

	// every transfer starts at the low byte
	// each written or read byte moves to the other half, so the index wraps modulo 2
	always_ff @(posedge CLK) begin
		if (reset) begin
			byte_idx <= 1'b0;
		end else if (start_xfer) begin
			byte_idx <= 1'b0;
		end else if (commit_byte || next_byte) begin
			byte_idx <= ~byte_idx;
		end
	end

	// a write lands in the half the index points at before it toggles
	// the LED byte is bits 15:8, the second byte of a write
	// a third byte wraps around and replaces the low half
	always_ff @(posedge CLK) begin
		if (reset) begin
			ctrl_word <= '0;
		end else if (commit_byte) begin
			if (byte_idx) begin
				ctrl_word[15:8] <= rx_byte;
			end else begin
				ctrl_word[7:0] <= rx_byte;
			end
		end
	end

	// the snapshot keeps both read bytes from one sample of status
	// even when status changes while the first byte is on the bus
	always_ff @(posedge CLK) begin
		if (snap_status) begin
			snap <= status;
		end
	end

	// the shift register loads this byte at the end of each ack pulse
	// by then the index has already moved to the byte that goes next
	assign tx_byte = byte_idx ? snap[15:8] : snap[7:0];

endmodule

// ==== i2c_slave/i2c_shift_reg.sv ====
`timescale 1ns/1ps

module i2c_shift_reg (
	input  logic           CLK,
	input  logic           reset,
	input  logic           shift_in,
	input  logic           shift_out,
	input  logic           load_tx,
	input  logic           sda_f,
	input  i2c_pkg::byte_t tx_byte,
	output i2c_pkg::byte_t rx_byte,
	output logic           tx_bit
);
	import i2c_pkg::*;

	byte_t tx_sr;

	// receive side
	// the first bit on the bus is the MSB, so bits enter at the bottom and move up
	// after eight shift_in strobes rx_byte holds the whole byte
	// it then stays put through the ack phase, where the FSM and the reg bank read it
	always_ff @(posedge CLK) begin
		if (reset) begin
			rx_byte <= '0;
		end else if (shift_in) begin
			rx_byte <= {rx_byte[6:0], sda_f};
		end
	end

	// transmit side
	// the MSB of tx_sr is always the bit on the bus
	// a load takes the next status byte from the reg bank
	// each shift_out moves the next bit up and fills with 1 so SDA ends released
	// a load wins over a shift, though the FSM never asks for both at once
	always_ff @(posedge CLK) begin
		if (reset) begin
			tx_sr <= '1;
		end else if (load_tx) begin
			tx_sr <= tx_byte;
		end else if (shift_out) begin
			tx_sr <= {tx_sr[6:0], 1'b1};
		end
	end

	// only a 0 here pulls SDA, and only while the FSM is sending data
	assign tx_bit = tx_sr[7];

endmodule

// ==== i2c_slave/i2c_slave_fsm.sv ====
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_slave_fsm (
	input  logic              CLK,
	input  logic              reset,
	input  logic              scl_f,
	input  logic              sda_f,
	input  logic              byte_done,
	input  i2c_pkg::bit_cnt_t bit_count,
	input  i2c_pkg::byte_t    rx_byte,
	input  logic              tx_bit,
	output logic              cnt_clear,
	output logic              scl_rise,
	output logic              shift_in,
	output logic              shift_out,
	output logic              load_tx,
	output logic              snap_status,
	output logic              commit_byte,
	output logic              next_byte,
	output logic              start_xfer,
	output logic              sda_low
);
	import i2c_pkg::*;

	localparam addr_t    SLAVE_ADDR = `I2C_SLAVE_ADDR;
	localparam bit_cnt_t BYTE_BITS = 4'd8;

	i2c_state_e state;
	logic       scl_q;
	logic       sda_q;
	logic       scl_up;
	logic       scl_dn;
	logic       start_det;
	logic       stop_det;
	logic       addr_hit;
	logic       ack_low;
	logic       tx_en;
	logic       master_nack;

	// previous filtered levels, so every edge shows up one cycle after the change
	always_ff @(posedge CLK) begin
		if (reset) begin
			scl_q <= 1'b1;
			sda_q <= 1'b1;
		end else begin
			scl_q <= scl_f;
			sda_q <= sda_f;
		end
	end

	assign scl_up = scl_f & ~scl_q;
	assign scl_dn = ~scl_f & scl_q;
	// SDA may only move with SCL high to mark a start or a stop
	assign start_det = scl_f & scl_q & sda_q & ~sda_f;
	assign stop_det = scl_f & scl_q & ~sda_q & sda_f;
	assign addr_hit = (rx_byte[7:1] == SLAVE_ADDR);

	// every ack phase sees two SCL falls
	// with bit_count at 8 it is the fall after bit 8 and the ack is set up
	// the counter is cleared there, so the next fall ends the ack pulse
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= IDLE;
			cnt_clear <= 1'b0;
			scl_rise <= 1'b0;
			shift_in <= 1'b0;
			shift_out <= 1'b0;
			load_tx <= 1'b0;
			snap_status <= 1'b0;
			commit_byte <= 1'b0;
			next_byte <= 1'b0;
			start_xfer <= 1'b0;
			ack_low <= 1'b0;
			tx_en <= 1'b0;
			master_nack <= 1'b0;
		end else begin
			cnt_clear <= 1'b0;
			scl_rise <= 1'b0;
			shift_in <= 1'b0;
			shift_out <= 1'b0;
			load_tx <= 1'b0;
			snap_status <= 1'b0;
			commit_byte <= 1'b0;
			next_byte <= 1'b0;
			start_xfer <= 1'b0;
			// drive data only once the transmit register holds the new byte
			if (load_tx) begin
				tx_en <= 1'b1;
			end
			if (start_det) begin
				// a start from any state, repeated or not, begins address decoding
				state <= ADDR;
				cnt_clear <= 1'b1;
				start_xfer <= 1'b1;
				ack_low <= 1'b0;
				tx_en <= 1'b0;
			end else if (stop_det) begin
				state <= IDLE;
				ack_low <= 1'b0;
				tx_en <= 1'b0;
			end else begin
				case (state)
					ADDR, WRITE: begin
						if (scl_up) begin
							scl_rise <= 1'b1;
							shift_in <= 1'b1;
						end
						if (byte_done) begin
							state <= (state == ADDR) ? ADDR_ACK : WRITE_ACK;
						end
					end
					READ: begin
						// the master samples on the rise and the next bit goes out on the fall
						if (scl_up) begin
							scl_rise <= 1'b1;
						end
						if (scl_dn) begin
							shift_out <= 1'b1;
						end
						if (byte_done) begin
							state <= READ_ACK;
						end
					end
					ADDR_ACK: begin
						if (scl_dn && bit_count == BYTE_BITS) begin
							cnt_clear <= 1'b1;
							if (addr_hit) begin
								ack_low <= 1'b1;
								// a read freezes status here so both bytes match
								snap_status <= rx_byte[0];
							end else begin
								state <= IGNORE;
							end
						end else if (scl_dn) begin
							ack_low <= 1'b0;
							if (rx_byte[0]) begin
								state <= READ;
								load_tx <= 1'b1;
							end else begin
								state <= WRITE;
							end
						end
					end
					WRITE_ACK: begin
						if (scl_dn && bit_count == BYTE_BITS) begin
							cnt_clear <= 1'b1;
							ack_low <= 1'b1;
							commit_byte <= 1'b1;
						end else if (scl_dn) begin
							ack_low <= 1'b0;
							state <= WRITE;
						end
					end
					READ_ACK: begin
						// the ninth rise carries the master's ack, high means NACK
						if (scl_up) begin
							master_nack <= sda_f;
						end
						if (scl_dn && bit_count == BYTE_BITS) begin
							// release SDA for the master and point at the other byte
							cnt_clear <= 1'b1;
							tx_en <= 1'b0;
							next_byte <= 1'b1;
						end else if (scl_dn && master_nack) begin
							state <= IGNORE;
						end else if (scl_dn) begin
							state <= READ;
							load_tx <= 1'b1;
						end
					end
					default: begin
						// IDLE and IGNORE only leave on a start
					end
				endcase
			end
		end
	end

	assign sda_low = ack_low | (tx_en & ~tx_bit);

	// SDA stays released while no transfer to this slave is under way
	assert property (@(posedge CLK) disable iff (reset)
		(state == IDLE || state == IGNORE) |-> !sda_low)
		else $error("sda pulled low in state %s", state.name());

	// data reaches the control word only at the slave's own acknowledge
	assert property (@(posedge CLK) disable iff (reset)
		commit_byte |-> state == WRITE_ACK)
		else $error("commit_byte outside WRITE_ACK");

endmodule

// ==== logic/deglitch.sv ====
`timescale 1ns/1ps
`include "i2c_config.svh"

module deglitch (
	input  logic CLK,
	input  logic reset,
	input  logic in,
	output logic out
);
	localparam int N = `DEGLITCH_SAMPLES;
	localparam int CW = $clog2(N + 1);

	// hist[0] is the newest sample and the older ones follow it
	logic [N-1:0]  hist;
	// length of the current run of equal samples, saturating at N
	logic [CW-1:0] run_len;
	logic          same;

	assign same = (in == hist[0]);

	// the output moves on the edge that takes the Nth equal sample
	// after reset the line is assumed idle high with a full run behind it
	always_ff @(posedge CLK) begin
		if (reset) begin
			hist <= '1;
			run_len <= CW'(N);
			out <= 1'b1;
		end else begin
			hist <= {hist[N-2:0], in};
			if (!same) begin
				// a new level starts a new run of one sample
				run_len <= CW'(1);
			end else if (run_len < CW'(N)) begin
				run_len <= run_len + 1'b1;
			end
			if (same && run_len >= CW'(N - 1)) begin
				out <= in;
			end
		end
	end

	// whenever the filtered level moves, the whole history already shows it
	assert property (@(posedge CLK) disable iff (reset)
		!$stable(out) |-> (hist == {N{out}}))
		else $error("deglitch output moved without %0d equal samples", N);

endmodule

// ==== logic/i2c_periph_top.sv ====
`timescale 1ns/1ps

module i2c_periph_top (
	input  logic           CLK,
	input  logic           reset,
	input  logic           scl,
	inout  wire            sda,
	input  i2c_pkg::word_t status,
	output i2c_pkg::word_t ctrl_word
);
	import i2c_pkg::*;

	// filtered bus levels
	logic     scl_f;
	logic     sda_f;

	// one-cycle strobes from the FSM
	logic     cnt_clear;
	logic     scl_rise;
	logic     shift_in;
	logic     shift_out;
	logic     load_tx;
	logic     snap_status;
	logic     commit_byte;
	logic     next_byte;
	logic     start_xfer;
	logic     sda_low;

	// results returned to the FSM and between the datapath blocks
	logic     byte_done;
	bit_cnt_t bit_count;
	byte_t    rx_byte;
	byte_t    tx_byte;
	logic     tx_bit;

	// both bus lines go through the same stability filter
	deglitch scl_filt_i (.CLK(CLK), .reset(reset), .in(scl), .out(scl_f));
	deglitch sda_filt_i (.CLK(CLK), .reset(reset), .in(sda), .out(sda_f));

	i2c_slave_fsm fsm_i (
		.CLK(CLK), .reset(reset), .scl_f(scl_f), .sda_f(sda_f),
		.byte_done(byte_done), .bit_count(bit_count), .rx_byte(rx_byte), .tx_bit(tx_bit),
		.cnt_clear(cnt_clear), .scl_rise(scl_rise), .shift_in(shift_in),
		.shift_out(shift_out), .load_tx(load_tx), .snap_status(snap_status),
		.commit_byte(commit_byte), .next_byte(next_byte), .start_xfer(start_xfer),
		.sda_low(sda_low)
	);

	i2c_bit_counter bit_cnt_i (
		.CLK(CLK), .reset(reset), .cnt_clear(cnt_clear), .scl_rise(scl_rise),
		.byte_done(byte_done), .bit_count(bit_count)
	);

	i2c_shift_reg shift_i (
		.CLK(CLK), .reset(reset), .shift_in(shift_in), .shift_out(shift_out),
		.load_tx(load_tx), .sda_f(sda_f), .tx_byte(tx_byte),
		.rx_byte(rx_byte), .tx_bit(tx_bit)
	);

	i2c_reg_bank regs_i (
		.CLK(CLK), .reset(reset), .start_xfer(start_xfer), .snap_status(snap_status),
		.commit_byte(commit_byte), .next_byte(next_byte), .rx_byte(rx_byte),
		.status(status), .tx_byte(tx_byte), .ctrl_word(ctrl_word)
	);

	// open drain, the slave only ever pulls SDA down and the pull-up makes the 1
	assign sda = sda_low ? 1'b0 : 1'bz;

endmodule

// ==== vlog.f ====
+incdir+common
common/i2c_pkg.sv
logic/deglitch.sv
i2c_slave/i2c_bit_counter.sv
i2c_slave/i2c_shift_reg.sv
i2c_slave/i2c_reg_bank.sv
i2c_slave/i2c_slave_fsm.sv
logic/i2c_periph_top.sv
dv/tb_i2c_periph.sv
